// File: include/buf_params.svh
/*
  sizing macros for the paced drain buffer
  data width, fifo depth, read mode, divider and drop counter widths
*/

`ifndef BUF_PARAMS_SVH
`define BUF_PARAMS_SVH

// width of one stored word
`define BUF_DATA_W 16

// number of fifo entries
`define BUF_DEPTH 8

// 1 = show-ahead read, 0 = registered read at pop
`define BUF_FWFT 1

// pacing divider and drop counter widths
`define PACE_DIV_W 16
`define BUF_DROP_W 8

`endif

// File: logic/buf_pkg.sv
/*
  buffer types
  data word, fill level and saturating drop count
*/

`default_nettype none

`include "buf_params.svh"

package buf_pkg;

  // --------------------
  // payload
  // --------------------

  // one word as pushed by a producer
  typedef logic [`BUF_DATA_W-1:0] buf_data_t;

  // --------------------
  // status
  // --------------------

  // fill level, one bit wider than needed for the pointers so full fits
  typedef logic [$clog2(`BUF_DEPTH+1)-1:0] buf_cnt_t;

  // drop count, saturates at all ones
  typedef logic [`BUF_DROP_W-1:0] buf_drop_t;

endpackage

`default_nettype wire

// File: logic/pace_pkg.sv
/*
  pacing types
  divider word and tap index
*/

`default_nettype none

`include "buf_params.svh"

package pace_pkg;

  // free-running divider
  typedef logic [`PACE_DIV_W-1:0] pace_div_t;

  // selects one divider bit
  typedef logic [3:0] pace_tap_t;

endpackage

`default_nettype wire

// File: logic/fifo_if.sv
/*
  fifo read side
  pop request, write-accept hint, head word, empty flag, fill level
*/

`timescale 1ns/1ns
`default_nettype none

interface fifo_if;

  // from the drain side
  logic r_req;
  logic pop_ok;

  // from the fifo
  buf_pkg::buf_data_t r_data;
  logic               empty;
  buf_pkg::buf_cnt_t  cnt;

  // fifo storage side
  modport fifo (
    input  r_req, pop_ok,
    output r_data, empty, cnt
  );

  // pop controller side
  modport drain (
    output r_req, pop_ok,
    input  r_data, empty, cnt
  );

endinterface

`default_nettype wire

// File: logic/fifo_reg.sv
/*
  register-array fifo, single clock
  show-ahead or registered read, selected by BUF_FWFT
  write accepted when not full or when a pop happens in the same cycle
*/

`timescale 1ns/1ns
`default_nettype none

`include "buf_params.svh"

module fifo_reg (
  input  logic               clk200,
  input  logic               nrst,
  input  logic               w_req,
  input  buf_pkg::buf_data_t w_data,
  output logic               full,
  fifo_if.fifo               rd
);

  localparam int PTR_W = $clog2(`BUF_DEPTH);

  // --------------------
  // storage and pointers
  // --------------------

  buf_pkg::buf_data_t mem [`BUF_DEPTH];

  logic [PTR_W-1:0]  w_ptr;
  logic [PTR_W-1:0]  r_ptr;
  buf_pkg::buf_cnt_t cnt_q;

  logic do_write;
  logic do_read;

  // underflow guard, a pop on empty does nothing
  assign do_read = rd.r_req & ~rd.empty;

  // overflow guard, full is fine if the head leaves this cycle
  assign do_write = w_req & (~full | rd.pop_ok);

  // flags straight from the counter
  assign full     = (cnt_q == buf_pkg::buf_cnt_t'(`BUF_DEPTH));
  assign rd.empty = (cnt_q == '0);
  assign rd.cnt   = cnt_q;

  // payload, no reset
  always_ff @(posedge clk200) begin
    if (do_write) begin
      mem[w_ptr] <= w_data;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk200) begin
    if (!nrst) begin
      w_ptr <= '0;
      r_ptr <= '0;
      cnt_q <= '0;
    end else begin
      if (do_write) begin
        // explicit wrap, depth need not be a power of two
        if (w_ptr == PTR_W'(`BUF_DEPTH - 1)) begin
          w_ptr <= '0;
        end else begin
          w_ptr <= w_ptr + 1'b1;
        end
      end

      if (do_read) begin
        if (r_ptr == PTR_W'(`BUF_DEPTH - 1)) begin
          r_ptr <= '0;
        end else begin
          r_ptr <= r_ptr + 1'b1;
        end
      end

      // simultaneous push and pop keeps the level
      case ({do_write, do_read})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // --------------------
  // read port
  // --------------------

  if (`BUF_FWFT != 0) begin : g_fwft
    // head word visible before the pop
    assign rd.r_data = mem[r_ptr];
  end else begin : g_norm
    // word appears the cycle after the pop
    buf_pkg::buf_data_t r_data_q;

    always_ff @(posedge clk200) begin
      if (do_read) begin
        r_data_q <= mem[r_ptr];
      end
    end

    assign rd.r_data = r_data_q;
  end

  // --------------------
  // checks
  // --------------------

  // drain side must look at empty before popping
  a_no_pop_on_empty: assert property (
    @(posedge clk200) disable iff (!nrst) rd.r_req |-> !rd.empty
  );

  a_cnt_in_range: assert property (
    @(posedge clk200) disable iff (!nrst) rd.cnt <= buf_pkg::buf_cnt_t'(`BUF_DEPTH)
  );

  a_flags_exclusive: assert property (
    @(posedge clk200) disable iff (!nrst) !(full && rd.empty)
  );

endmodule

`default_nettype wire

// File: logic/pace_gen.sv
/*
  drain pacer
  free-running divider, tap select, one-cycle tick per rising edge
*/

`timescale 1ns/1ns
`default_nettype none

module pace_gen (
  input  logic                clk200,
  input  logic                nrst,
  input  pace_pkg::pace_tap_t tap_sel,
  output logic                tick
);

  // --------------------
  // divider
  // --------------------

  pace_pkg::pace_div_t div_q;

  // selected bit and its value one cycle ago
  logic tap_now;
  logic tap_d;

  // bit n toggles every 2^n cycles, so rises every 2^(n+1)
  assign tap_now = div_q[tap_sel];

  always_ff @(posedge clk200) begin
    if (!nrst) begin
      div_q <= '0;
      tap_d <= 1'b0;
      tick  <= 1'b0;
    end else begin
      div_q <= div_q + 1'b1;
      tap_d <= tap_now;
      // registered rising edge
      tick  <= tap_now & ~tap_d;
    end
  end

  // --------------------
  // checks
  // --------------------

  // holds across tap changes too, tap_d is high after any tick
  a_tick_single: assert property (
    @(posedge clk200) disable iff (!nrst) tick |=> !tick
  );

endmodule

`default_nettype wire

// File: logic/drain_ctrl.sv
/*
  drain control
  pop on tick, output word and strobe, saturating drop counter
*/

`timescale 1ns/1ns
`default_nettype none

`include "buf_params.svh"

module drain_ctrl (
  input  logic               clk200,
  input  logic               nrst,
  input  logic               tick,
  input  logic               wr_stb,
  input  logic               full,
  fifo_if.drain              rd,
  output logic               rd_stb,
  output buf_pkg::buf_data_t rd_data,
  output buf_pkg::buf_drop_t drop_cnt
);

  // --------------------
  // pop
  // --------------------

  // a tick on empty is simply lost
  logic pop;
  assign pop = tick & ~rd.empty;

  assign rd.r_req  = pop;
  // same strobe, lets a full fifo take a write
  assign rd.pop_ok = pop;

  // strobe one cycle after the pop
  always_ff @(posedge clk200) begin
    if (!nrst) begin
      rd_stb <= 1'b0;
    end else begin
      rd_stb <= pop;
    end
  end

  // output word, both modes line up with rd_stb
  if (`BUF_FWFT != 0) begin : g_fwft
    // head is already on r_data, grab it at the pop edge
    buf_pkg::buf_data_t hold_q;

    always_ff @(posedge clk200) begin
      if (pop) begin
        hold_q <= rd.r_data;
      end
    end

    assign rd_data = hold_q;
  end else begin : g_norm
    // fifo registers the word itself
    assign rd_data = rd.r_data;
  end

  // --------------------
  // drops
  // --------------------

  logic drop;
  assign drop = wr_stb & full & ~pop;

  always_ff @(posedge clk200) begin
    if (!nrst) begin
      drop_cnt <= '0;
    end else if (drop && (drop_cnt != '1)) begin
      drop_cnt <= drop_cnt + 1'b1;
    end
  end

  a_stb_after_req: assert property (
    @(posedge clk200) disable iff (!nrst) rd_stb |-> $past(rd.r_req)
  );

endmodule

`default_nettype wire

// File: logic/paced_fifo_top.sv
/*
  paced drain buffer top
  fifo, pacer and drain controller joined by one fifo_if
*/

`timescale 1ns/1ns
`default_nettype none

module paced_fifo_top (
  input  logic                clk200,
  input  logic                nrst,
  // producer side
  input  logic                wr_stb,
  input  buf_pkg::buf_data_t  wr_data,
  // drain rate
  input  pace_pkg::pace_tap_t tap_sel,
  // consumer side
  output logic                rd_stb,
  output buf_pkg::buf_data_t  rd_data,
  // status
  output logic                full,
  output logic                empty,
  output buf_pkg::buf_cnt_t   cnt,
  output buf_pkg::buf_drop_t  drop_cnt
);

  // --------------------
  // internal wiring
  // --------------------

  fifo_if fifo_rd ();

  logic tick;

  // status comes straight off the fifo
  assign empty = fifo_rd.empty;
  assign cnt   = fifo_rd.cnt;

  fifo_reg i_fifo_reg (
    .clk200 (clk200),
    .nrst   (nrst),
    .w_req  (wr_stb),
    .w_data (wr_data),
    .full   (full),
    .rd     (fifo_rd.fifo)
  );

  pace_gen i_pace_gen (
    .clk200  (clk200),
    .nrst    (nrst),
    .tap_sel (tap_sel),
    .tick    (tick)
  );

  drain_ctrl i_drain_ctrl (
    .clk200   (clk200),
    .nrst     (nrst),
    .tick     (tick),
    .wr_stb   (wr_stb),
    .full     (full),
    .rd       (fifo_rd.drain),
    .rd_stb   (rd_stb),
    .rd_data  (rd_data),
    .drop_cnt (drop_cnt)
  );

endmodule

`default_nettype wire

// File: verif/paced_fifo_tb.sv
/*
  testbench for the paced drain buffer
  phase table of lcg traffic, reference queue model, per-cycle checks
  watchdog sized from the phase table
*/

`timescale 1ns/1ns
`default_nettype none

`include "buf_params.svh"

module paced_fifo_tb;

  // --------------------
  // phase table
  // --------------------

  typedef struct packed {
    logic [31:0] cycles;
    logic [3:0]  tap;
    logic [7:0]  thresh;
    logic        want_drops;
    logic        want_empty;
  } phase_t;

  localparam int NPHASE = 7;

  // write when one byte of the draw is below thresh, so thresh is out of 256
  localparam phase_t PHASES [NPHASE] = '{
    '{32'd200, 4'd0, 8'd64,  1'b0, 1'b0},  // sparse warm-up, fast drain
    '{32'd600, 4'd7, 8'd230, 1'b1, 1'b0},  // dense writes, slow drain, saturates drops
    '{32'd40,  4'd0, 8'd0,   1'b0, 1'b1},  // no writes, drain to empty
    '{32'd300, 4'd2, 8'd160, 1'b1, 1'b0},  // medium drain, still overflows
    '{32'd60,  4'd0, 8'd0,   1'b0, 1'b1},
    '{32'd300, 4'd1, 8'd24,  1'b0, 1'b0},  // sparse writes, never fills
    '{32'd40,  4'd0, 8'd0,   1'b0, 1'b1}
  };

  localparam int unsigned DROP_MAX = (1 << `BUF_DROP_W) - 1;

  // --------------------
  // dut signals
  // --------------------

  logic                clk200;
  logic                nrst;
  logic                wr_stb;
  buf_pkg::buf_data_t  wr_data;
  pace_pkg::pace_tap_t tap_sel;
  logic                rd_stb;
  buf_pkg::buf_data_t  rd_data;
  logic                full;
  logic                empty;
  buf_pkg::buf_cnt_t   cnt;
  buf_pkg::buf_drop_t  drop_cnt;

  // reference model state
  buf_pkg::buf_data_t model_q [$];
  int unsigned        drop_model;
  int unsigned        drop_total;
  logic               cur_stb;
  buf_pkg::buf_data_t cur_data;
  logic               prev_stb;
  buf_pkg::buf_data_t prev_data;
  logic [31:0]        rnd_state;

  always #10 clk200 = ~clk200;

  paced_fifo_top i_paced_fifo_top (
    .clk200   (clk200),
    .nrst     (nrst),
    .wr_stb   (wr_stb),
    .wr_data  (wr_data),
    .tap_sel  (tap_sel),
    .rd_stb   (rd_stb),
    .rd_data  (rd_data),
    .full     (full),
    .empty    (empty),
    .cnt      (cnt),
    .drop_cnt (drop_cnt)
  );

  // --------------------
  // helpers
  // --------------------

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run;
    $display("TEST FAILED");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      abort_run();
    end
  endtask

  task automatic halt_with_reason(input string why);
    $display("%s at %0t", why, $time);
    abort_run();
  endtask

  // one draw for the strobe, the next for the word
  task automatic drive_cycle(input phase_t ph);
    rnd_state = lcg_next(rnd_state);
    cur_stb   = (rnd_state[23:16] < ph.thresh);
    rnd_state = lcg_next(rnd_state);
    cur_data  = rnd_state[31:16];
    wr_stb  <= cur_stb;
    wr_data <= cur_data;
    tap_sel <= ph.tap;
  endtask

  // rd_stb now means a pop at the last edge, where last cycle's write landed too
  task automatic settle_cycle;
    int size_before;
    buf_pkg::buf_data_t head;
    size_before = model_q.size();
    if (rd_stb) begin
      if (size_before == 0) begin
        halt_with_reason("rd_stb seen while the reference queue is empty");
      end else begin
        head = model_q.pop_front();
        check_val("rd_data", 32'(rd_data), 32'(head));
      end
    end
    if (prev_stb) begin
      if ((size_before < `BUF_DEPTH) || rd_stb) begin
        model_q.push_back(prev_data);
      end else begin
        drop_total++;
        if (drop_model != DROP_MAX) begin
          drop_model++;
        end
      end
    end
    check_val("cnt", 32'(cnt), 32'(model_q.size()));
    check_val("full", 32'(full), 32'(model_q.size() == `BUF_DEPTH));
    check_val("empty", 32'(empty), 32'(model_q.size() == 0));
    check_val("drop_cnt", 32'(drop_cnt), drop_model);
    prev_stb  = cur_stb;
    prev_data = cur_data;
  endtask

  // --------------------
  // main sequence
  // --------------------

  initial begin
    int unsigned drops_start;
    clk200     = 1'b0;
    nrst       = 1'b0;
    wr_stb     = 1'b0;
    wr_data    = '0;
    tap_sel    = '0;
    rnd_state  = 32'h970e;
    drop_model = 0;
    drop_total = 0;
    cur_stb    = 1'b0;
    cur_data   = '0;
    prev_stb   = 1'b0;
    prev_data  = '0;
    drops_start = 0;
    $display("read mode BUF_FWFT = %0d", `BUF_FWFT);

    repeat (3) @(posedge clk200);
    nrst <= 1'b1;
    @(negedge clk200);

    // state straight out of reset
    check_val("empty", 32'(empty), 32'd1);
    check_val("full", 32'(full), 32'd0);
    check_val("cnt", 32'(cnt), 32'd0);
    check_val("drop_cnt", 32'(drop_cnt), 32'd0);
    check_val("rd_stb", 32'(rd_stb), 32'd0);

    for (int p = 0; p < NPHASE; p++) begin
      for (int c = 0; c < int'(PHASES[p].cycles); c++) begin
        @(posedge clk200);
        drive_cycle(PHASES[p]);
        @(negedge clk200);
        settle_cycle();
        // first settle still belongs to the previous phase
        if (c == 0) begin
          drops_start = drop_total;
        end
      end
      if (PHASES[p].want_drops) begin
        check_val("drops_in_phase", 32'(drop_total > drops_start), 32'd1);
      end else begin
        check_val("drops_in_phase", drop_total - drops_start, 32'd0);
      end
      if (PHASES[p].want_empty) begin
        check_val("empty_at_phase_end", 32'(empty), 32'd1);
      end
    end

    $display("TEST PASSED");
    $finish;
  end

  // --------------------
  // watchdog
  // --------------------

  initial begin : watchdog
    int total;
    total = 3;
    for (int p = 0; p < NPHASE; p++) begin
      total += int'(PHASES[p].cycles);
    end
    #((total + 100) * 20);
    halt_with_reason("watchdog expired before the phase table finished");
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+include
logic/buf_pkg.sv
logic/pace_pkg.sv
logic/fifo_if.sv
logic/fifo_reg.sv
logic/pace_gen.sv
logic/drain_ctrl.sv
logic/paced_fifo_top.sv
verif/paced_fifo_tb.sv

// File: Makefile
# Verilator build, run, lint and clean for the paced drain buffer

TOP := paced_fifo_tb
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): verilog.f $(wildcard include/*.svh logic/*.sv verif/*.sv)
	verilator --binary --timing -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir

# pass or fail is taken from the log, not from the pipe status
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

lint:
	verilator --lint-only --timing -f verilog.f --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
